//--- design/addr_pkg.sv
package addr_pkg;

    // Addressing modes handled by the unit
    typedef enum logic [2:0] {
        mode_zpg   = 3'd0,
        mode_zpg_x = 3'd1,
        mode_zpg_y = 3'd2,
        mode_abs   = 3'd3,
        mode_abs_x = 3'd4,
        mode_abs_y = 3'd5,
        mode_ind_x = 3'd6,
        mode_ind_y = 3'd7
    } addr_mode_t;

    // Micro-states of one addressing sequence
    typedef enum logic [1:0] {
        seq_a0 = 2'd0,
        seq_a1 = 2'd1,
        seq_a2 = 2'd2,
        seq_a3 = 2'd3
    } seq_state_t;

    // Target of a host configuration write
    typedef enum logic [1:0] {
        sel_a = 2'd0,
        sel_x = 2'd1,
        sel_y = 2'd2
    } reg_sel_t;

    // At most one bit set, all clear for loads
    typedef struct packed {
        logic st_acc;
        logic st_x;
        logic st_y;
    } store_kind_t;

    typedef struct packed {
        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;
    } opcode_fields_t;

    typedef union packed {
        logic [7:0]     raw;
        opcode_fields_t f;
    } opcode_u;

    typedef struct packed {
        // PC and address-bus loads
        logic pc_inc;
        logic load_abl;
        logic load_abh;
        // ADL sources
        logic adl_to_data;
        logic adl_to_pcl;
        logic adl_to_alu;
        // ADH sources
        logic adh_low;
        logic adh_to_data;
        logic adh_to_pch;
        logic adh_to_sb;
        // DB sources
        logic db_to_data;
        logic db_to_acc;
        logic db_to_sb;
        // SB sources
        logic sb_to_x;
        logic sb_to_y;
        logic sb_to_alu;
        // ALU inputs and operation
        logic in_a_to_sb;
        logic in_a_to_low;
        logic in_b_to_db;
        logic alu_carry_high;
        logic alu_carry_from_free;
        logic load_alu;
        logic alu_add;
        // Carry latch and store data
        logic free_carry_from_alu;
        logic load_dor;
    } ctrl_flags_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        we;
    } mem_req_t;

    // Number of micro-states per mode, indexed by addr_mode_t
    localparam logic [2:0] MODE_STATES [0:7] = '{
        3'd1, 3'd2, 3'd2, 3'd2, 3'd3, 3'd3, 3'd4, 3'd4
    };

endpackage

//--- design/index_reg_bank.sv
`timescale 1ns/1ps

module index_reg_bank (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cfg_we,
    input  addr_pkg::reg_sel_t cfg_sel,
    input  logic [7:0]        cfg_data,
    input  logic              busy,
    output logic [7:0]        reg_a,
    output logic [7:0]        reg_x,
    output logic [7:0]        reg_y
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_a <= 8'h00;
            reg_x <= 8'h00;
            reg_y <= 8'h00;
        end else if (cfg_we && !busy) begin
            case (cfg_sel)
                addr_pkg::sel_a: reg_a <= cfg_data;
                addr_pkg::sel_x: reg_x <= cfg_data;
                addr_pkg::sel_y: reg_y <= cfg_data;
                default: ;
            endcase
        end
    end

    // Host writes during a sequence must not disturb the operands
    a_no_cfg_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_we && busy |=> $stable({reg_a, reg_x, reg_y}))
        else $error("index_reg_bank: register changed by cfg_we while busy");

endmodule

//--- design/opcode_decode.sv
`timescale 1ns/1ps

module opcode_decode (
    input  addr_pkg::opcode_u     opcode,
    output addr_pkg::addr_mode_t  mode,
    output addr_pkg::store_kind_t store,
    output logic                  bad
);

    logic is_st;
    logic is_ld;
    logic acc_grp;
    logic x_grp;

    assign is_st   = (opcode.f.aaa == 3'b100);
    assign is_ld   = (opcode.f.aaa == 3'b101);
    assign acc_grp = (opcode.f.cc == 2'b01);
    assign x_grp   = (opcode.f.cc == 2'b10);

    always_comb begin
        mode  = addr_pkg::mode_zpg;
        store = '0;
        bad   = 1'b0;
        case (opcode.f.bbb)
            // X and Y groups use this slot for immediates
            3'b000: begin
                mode = addr_pkg::mode_ind_x;
                bad  = !acc_grp;
            end
            3'b001: mode = addr_pkg::mode_zpg;
            // Immediate or implied in every group
            3'b010: bad = 1'b1;
            3'b011: mode = addr_pkg::mode_abs;
            3'b100: begin
                mode = addr_pkg::mode_ind_y;
                bad  = !acc_grp;
            end
            // LDX/STX index with Y instead of X
            3'b101: mode = x_grp ? addr_pkg::mode_zpg_y : addr_pkg::mode_zpg_x;
            3'b110: begin
                mode = addr_pkg::mode_abs_y;
                bad  = !acc_grp;
            end
            default: begin
                // Only the load exists in the indexed absolute X/Y-group slot
                mode = x_grp ? addr_pkg::mode_abs_y : addr_pkg::mode_abs_x;
                bad  = !acc_grp && is_st;
            end
        endcase
        if (!(is_st || is_ld) || opcode.f.cc == 2'b11) begin
            bad = 1'b1;
        end
        if (bad) begin
            mode = addr_pkg::mode_zpg;
        end else begin
            store.st_acc = is_st && acc_grp;
            store.st_x   = is_st && x_grp;
            store.st_y   = is_st && (opcode.f.cc == 2'b00);
        end
    end

endmodule

//--- design/addr_seq.sv
`timescale 1ns/1ps

module addr_seq (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  addr_pkg::addr_mode_t  mode_in,
    input  addr_pkg::store_kind_t store_in,
    input  logic                  bad,
    output addr_pkg::seq_state_t  state,
    output addr_pkg::addr_mode_t  mode,
    output addr_pkg::store_kind_t store,
    output logic                  busy,
    output logic                  done,
    output logic                  bad_op
);

    logic [2:0] n_states;
    logic       bad_pend;

    assign n_states = addr_pkg::MODE_STATES[mode];
    // Last micro-state of the latched mode
    assign done = busy && ({1'b0, state} == n_states - 3'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= addr_pkg::seq_a0;
            mode     <= addr_pkg::mode_zpg;
            store    <= '0;
            busy     <= 1'b0;
            bad_pend <= 1'b0;
            bad_op   <= 1'b0;
        end else begin
            // Bad opcode strobe comes out one cycle after it is seen
            bad_pend <= start && !busy && bad;
            bad_op   <= bad_pend;
            if (!busy) begin
                if (start && !bad) begin
                    busy  <= 1'b1;
                    state <= addr_pkg::seq_a0;
                    mode  <= mode_in;
                    store <= store_in;
                end
            end else if (done) begin
                busy  <= 1'b0;
                state <= addr_pkg::seq_a0;
            end else begin
                state <= addr_pkg::seq_state_t'(state + 2'd1);
            end
        end
    end

    // Every sequence reaches its last state within four cycles
    a_busy_ends_in_done: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> ##[0:3] done)
        else $error("addr_seq: busy sequence did not reach done");

endmodule

//--- design/addr_mode_flags.sv
`timescale 1ns/1ps

module addr_mode_flags (
    input  addr_pkg::seq_state_t  state,
    input  addr_pkg::addr_mode_t  mode,
    input  addr_pkg::store_kind_t store,
    input  logic                  busy,
    output addr_pkg::ctrl_flags_t flags
);

    logic use_y;
    logic is_last;

    assign use_y   = (mode == addr_pkg::mode_zpg_y) || (mode == addr_pkg::mode_abs_y);
    assign is_last = ({1'b0, state} == addr_pkg::MODE_STATES[mode] - 3'd1);

    always_comb begin
        flags = '0;
        if (busy) begin
            case (mode)
                addr_pkg::mode_zpg: begin
                    flags.adl_to_data = 1'b1;
                    flags.adh_low     = 1'b1;
                    flags.load_abl    = 1'b1;
                    flags.load_abh    = 1'b1;
                end
                addr_pkg::mode_zpg_x, addr_pkg::mode_zpg_y: begin
                    if (state == addr_pkg::seq_a0) begin
                        // Operand plus index into the ALU
                        flags.db_to_data = 1'b1;
                        flags.in_b_to_db = 1'b1;
                        flags.sb_to_x    = !use_y;
                        flags.sb_to_y    = use_y;
                        flags.in_a_to_sb = 1'b1;
                        flags.alu_add    = 1'b1;
                        flags.load_alu   = 1'b1;
                    end else begin
                        // Sum wraps inside page zero
                        flags.adl_to_alu = 1'b1;
                        flags.adh_low    = 1'b1;
                        flags.load_abl   = 1'b1;
                        flags.load_abh   = 1'b1;
                    end
                end
                addr_pkg::mode_abs, addr_pkg::mode_abs_x, addr_pkg::mode_abs_y: begin
                    if (state == addr_pkg::seq_a0) begin
                        // Fetch next byte, low byte into the ALU
                        flags.pc_inc     = 1'b1;
                        flags.adl_to_pcl = 1'b1;
                        flags.adh_to_pch = 1'b1;
                        flags.load_abl   = 1'b1;
                        flags.load_abh   = 1'b1;
                        flags.db_to_data = 1'b1;
                        flags.in_b_to_db = 1'b1;
                        flags.in_a_to_low = (mode == addr_pkg::mode_abs);
                        flags.in_a_to_sb = (mode != addr_pkg::mode_abs);
                        flags.sb_to_x    = (mode == addr_pkg::mode_abs_x);
                        flags.sb_to_y    = (mode == addr_pkg::mode_abs_y);
                        flags.alu_add    = 1'b1;
                        flags.load_alu   = 1'b1;
                        flags.free_carry_from_alu = 1'b1;
                    end else if (mode == addr_pkg::mode_abs) begin
                        flags.adl_to_alu  = 1'b1;
                        flags.adh_to_data = 1'b1;
                        flags.load_abl    = 1'b1;
                        flags.load_abh    = 1'b1;
                    end else if (state == addr_pkg::seq_a1) begin
                        // Indexed low byte out, high byte plus carry
                        flags.adl_to_alu  = 1'b1;
                        flags.load_abl    = 1'b1;
                        flags.db_to_data  = 1'b1;
                        flags.in_b_to_db  = 1'b1;
                        flags.in_a_to_low = 1'b1;
                        flags.alu_carry_from_free = 1'b1;
                        flags.alu_add     = 1'b1;
                        flags.load_alu    = 1'b1;
                    end else begin
                        flags.sb_to_alu = 1'b1;
                        flags.adh_to_sb = 1'b1;
                        flags.load_abh  = 1'b1;
                    end
                end
                addr_pkg::mode_ind_x: begin
                    case (state)
                        addr_pkg::seq_a0: begin
                            // Pointer is operand plus X
                            flags.db_to_data = 1'b1;
                            flags.in_b_to_db = 1'b1;
                            flags.sb_to_x    = 1'b1;
                            flags.in_a_to_sb = 1'b1;
                            flags.alu_add    = 1'b1;
                            flags.load_alu   = 1'b1;
                        end
                        addr_pkg::seq_a1: begin
                            // Read pointer low, bump pointer through the ALU
                            flags.adl_to_alu     = 1'b1;
                            flags.adh_low        = 1'b1;
                            flags.load_abl       = 1'b1;
                            flags.load_abh       = 1'b1;
                            flags.sb_to_alu      = 1'b1;
                            flags.db_to_sb       = 1'b1;
                            flags.in_b_to_db     = 1'b1;
                            flags.in_a_to_low    = 1'b1;
                            flags.alu_carry_high = 1'b1;
                            flags.alu_add        = 1'b1;
                            flags.load_alu       = 1'b1;
                        end
                        addr_pkg::seq_a2: begin
                            flags.adl_to_alu  = 1'b1;
                            flags.adh_low     = 1'b1;
                            flags.load_abl    = 1'b1;
                            flags.load_abh    = 1'b1;
                            flags.db_to_data  = 1'b1;
                            flags.in_b_to_db  = 1'b1;
                            flags.in_a_to_low = 1'b1;
                            flags.alu_add     = 1'b1;
                            flags.load_alu    = 1'b1;
                        end
                        default: begin
                            flags.adl_to_alu  = 1'b1;
                            flags.adh_to_data = 1'b1;
                            flags.load_abl    = 1'b1;
                            flags.load_abh    = 1'b1;
                        end
                    endcase
                end
                default: begin
                    case (state)
                        addr_pkg::seq_a0: begin
                            // Read pointer low at the operand, ALU makes operand + 1
                            flags.adl_to_data    = 1'b1;
                            flags.adh_low        = 1'b1;
                            flags.load_abl       = 1'b1;
                            flags.load_abh       = 1'b1;
                            flags.db_to_data     = 1'b1;
                            flags.in_b_to_db     = 1'b1;
                            flags.in_a_to_low    = 1'b1;
                            flags.alu_carry_high = 1'b1;
                            flags.alu_add        = 1'b1;
                            flags.load_alu       = 1'b1;
                        end
                        addr_pkg::seq_a1: begin
                            // Low byte plus Y, carry kept for the high byte
                            flags.adl_to_alu = 1'b1;
                            flags.adh_low    = 1'b1;
                            flags.load_abl   = 1'b1;
                            flags.load_abh   = 1'b1;
                            flags.db_to_data = 1'b1;
                            flags.in_b_to_db = 1'b1;
                            flags.sb_to_y    = 1'b1;
                            flags.in_a_to_sb = 1'b1;
                            flags.alu_add    = 1'b1;
                            flags.load_alu   = 1'b1;
                            flags.free_carry_from_alu = 1'b1;
                        end
                        addr_pkg::seq_a2: begin
                            flags.adl_to_alu  = 1'b1;
                            flags.load_abl    = 1'b1;
                            flags.db_to_data  = 1'b1;
                            flags.in_b_to_db  = 1'b1;
                            flags.in_a_to_low = 1'b1;
                            flags.alu_carry_from_free = 1'b1;
                            flags.alu_add     = 1'b1;
                            flags.load_alu    = 1'b1;
                        end
                        default: begin
                            flags.sb_to_alu = 1'b1;
                            flags.adh_to_sb = 1'b1;
                            flags.load_abh  = 1'b1;
                        end
                    endcase
                end
            endcase
            // Store value goes to DOR in the last state
            if (is_last) begin
                flags.db_to_acc = store.st_acc;
                flags.db_to_sb  = flags.db_to_sb | store.st_x | store.st_y;
                flags.sb_to_x   = flags.sb_to_x | store.st_x;
                flags.sb_to_y   = flags.sb_to_y | store.st_y;
                flags.load_dor  = store.st_acc | store.st_x | store.st_y;
            end
        end
        assert ($onehot0({flags.adl_to_data, flags.adl_to_pcl, flags.adl_to_alu})
                && $onehot0({flags.adh_low, flags.adh_to_data, flags.adh_to_pch,
                             flags.adh_to_sb}))
            else $error("addr_mode_flags: more than one ADL or ADH source");
    end

endmodule

//--- design/addr_datapath.sv
`timescale 1ns/1ps

module addr_datapath (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [15:0]           pc,
    input  addr_pkg::ctrl_flags_t flags,
    input  logic [7:0]            mem_rdata,
    input  logic [7:0]            reg_a,
    input  logic [7:0]            reg_x,
    input  logic [7:0]            reg_y,
    input  logic                  done,
    output logic [15:0]           addr,
    output addr_pkg::mem_req_t    req,
    output logic                  req_valid
);

    logic [15:0] pc_q;
    logic [15:0] pc_next;
    logic [7:0]  abl;
    logic [7:0]  abh;
    logic [7:0]  db;
    logic [7:0]  sb;
    logic [7:0]  adl;
    logic [7:0]  adh;
    logic [7:0]  alu_a;
    logic [7:0]  alu_b;
    logic [7:0]  alu_q;
    logic [7:0]  alu_res;
    logic [8:0]  alu_sum;
    logic        alu_cin;
    logic        free_carry;
    logic [7:0]  dor;
    logic        st_we;

    // Incrementer sits between PC and the address buses
    assign pc_next = pc_q + {15'd0, flags.pc_inc};

    always_comb begin
        sb = 8'h00;
        if (flags.sb_to_x) sb = reg_x;
        else if (flags.sb_to_y) sb = reg_y;
        else if (flags.sb_to_alu) sb = alu_q;

        db = 8'h00;
        if (flags.db_to_data) db = mem_rdata;
        else if (flags.db_to_acc) db = reg_a;
        else if (flags.db_to_sb) db = sb;

        adl = 8'h00;
        if (flags.adl_to_data) adl = mem_rdata;
        else if (flags.adl_to_pcl) adl = pc_next[7:0];
        else if (flags.adl_to_alu) adl = alu_q;

        // Zero page when adh_low or nothing drives ADH
        adh = 8'h00;
        if (flags.adh_to_data) adh = mem_rdata;
        else if (flags.adh_to_pch) adh = pc_next[15:8];
        else if (flags.adh_to_sb && !flags.adh_low) adh = sb;
    end

    // A input forced to zero by in_a_to_low
    assign alu_a   = (flags.in_a_to_sb && !flags.in_a_to_low) ? sb : 8'h00;
    assign alu_b   = flags.in_b_to_db ? db : 8'h00;
    assign alu_cin = flags.alu_carry_high | (flags.alu_carry_from_free & free_carry);
    assign alu_sum = {1'b0, alu_a} + {1'b0, alu_b} + {8'd0, alu_cin};
    assign alu_res = flags.alu_add ? alu_sum[7:0] : (alu_a | alu_b);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q       <= 16'h0000;
            abl        <= 8'h00;
            abh        <= 8'h00;
            free_carry <= 1'b0;
            st_we      <= 1'b0;
            req_valid  <= 1'b0;
        end else begin
            req_valid <= done;
            if (start) begin
                pc_q <= pc;
                abl  <= pc[7:0];
                abh  <= pc[15:8];
            end else begin
                pc_q <= pc_next;
                if (flags.load_abl) abl <= adl;
                if (flags.load_abh) abh <= adh;
                if (flags.free_carry_from_alu) free_carry <= flags.alu_add & alu_sum[8];
                if (done) st_we <= flags.load_dor;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_q <= 8'h00;
            dor   <= 8'h00;
        end else begin
            if (flags.load_alu) alu_q <= alu_res;
            // Loads report zero write data
            if (done) dor <= flags.load_dor ? db : 8'h00;
        end
    end

    assign addr = {abh, abl};
    assign req  = '{addr: {abh, abl}, wdata: dor, we: st_we};

endmodule

//--- design/addr_unit.sv
`timescale 1ns/1ps

module addr_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cfg_we,
    input  addr_pkg::reg_sel_t cfg_sel,
    input  logic [7:0]         cfg_data,
    input  logic               start,
    input  addr_pkg::opcode_u  opcode,
    input  logic [15:0]        pc,
    input  logic [7:0]         mem_rdata,
    output logic [15:0]        addr,
    output logic               busy,
    output logic               req_valid,
    output addr_pkg::mem_req_t req,
    output logic               bad_op
);

    logic [7:0]            reg_a;
    logic [7:0]            reg_x;
    logic [7:0]            reg_y;
    addr_pkg::addr_mode_t  dec_mode;
    addr_pkg::store_kind_t dec_store;
    logic                  dec_bad;
    addr_pkg::seq_state_t  state;
    addr_pkg::addr_mode_t  seq_mode;
    addr_pkg::store_kind_t seq_store;
    logic                  done;
    addr_pkg::ctrl_flags_t flags;
    logic                  launch;

    // Only a good start from idle loads PC and AB
    assign launch = start && !busy && !dec_bad;

    index_reg_bank u_regs (
        .clk, .rst_n, .cfg_we, .cfg_sel, .cfg_data, .busy,
        .reg_a, .reg_x, .reg_y
    );

    opcode_decode u_dec (
        .opcode, .mode(dec_mode), .store(dec_store), .bad(dec_bad)
    );

    addr_seq u_seq (
        .clk, .rst_n, .start, .mode_in(dec_mode), .store_in(dec_store), .bad(dec_bad),
        .state, .mode(seq_mode), .store(seq_store), .busy, .done, .bad_op
    );

    addr_mode_flags u_flags (
        .state, .mode(seq_mode), .store(seq_store), .busy, .flags
    );

    addr_datapath u_dp (
        .clk, .rst_n, .start(launch), .pc, .flags, .mem_rdata,
        .reg_a, .reg_x, .reg_y, .done, .addr, .req, .req_valid
    );

endmodule

//--- verif/addr_unit_tb.sv
`timescale 1ns/1ps

module addr_unit_tb;

    localparam int NUM_OPS       = 400;
    localparam int CYCLES_PER_OP = 10;
    localparam int RESET_CYCLES  = 16;
    localparam int WATCHDOG_NS   = (NUM_OPS * CYCLES_PER_OP + RESET_CYCLES + 8) * 10;

    logic               clk;
    logic               rst_n;
    logic               cfg_we;
    addr_pkg::reg_sel_t cfg_sel;
    logic [7:0]         cfg_data;
    logic               start;
    addr_pkg::opcode_u  opcode;
    logic [15:0]        pc;
    logic [7:0]         mem_rdata;
    logic [15:0]        addr;
    logic               busy;
    logic               req_valid;
    addr_pkg::mem_req_t req;
    logic               bad_op;

    logic [7:0]  mem [0:65535];
    logic [15:0] lfsr;

    // Opcode in the top byte, then mode number, then store source (0 load, 1 A, 2 X, 3 Y)
    logic [15:0] legal_ops [0:27] = '{
        16'h8161, 16'h8501, 16'h8D31, 16'h9171, 16'h9511, 16'h9951, 16'h9D41,
        16'hA160, 16'hA500, 16'hAD30, 16'hB170, 16'hB510, 16'hB950, 16'hBD40,
        16'h8602, 16'h8E32, 16'h9622, 16'hA600, 16'hAE30, 16'hB620, 16'hBE50,
        16'h8403, 16'h8C33, 16'h9413, 16'hA400, 16'hAC30, 16'hB410, 16'hBC40
    };

    // Immediates, implied codes, missing indexed stores and foreign groups
    logic [7:0] illegal_ops [0:15] = '{
        8'h89, 8'hA9, 8'h82, 8'hA2, 8'h8A, 8'h92, 8'h9A, 8'h9E,
        8'h80, 8'hA0, 8'h90, 8'h9C, 8'h00, 8'hEA, 8'h83, 8'h61
    };

    addr_unit dut (
        .clk, .rst_n, .cfg_we, .cfg_sel, .cfg_data, .start, .opcode, .pc,
        .mem_rdata, .addr, .busy, .req_valid, .req, .bad_op
    );

    // Memory answers the address bus within the same cycle
    assign mem_rdata = mem[addr];

    initial begin : clock_gen
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic int state_count(input logic [3:0] mode);
        case (mode)
            4'd0: return 1;
            4'd1, 4'd2, 4'd3: return 2;
            4'd4, 4'd5: return 3;
            default: return 4;
        endcase
    endfunction

    function automatic logic [15:0] effective_addr(input logic [3:0] mode,
                                                   input logic [15:0] at,
                                                   input logic [7:0] x,
                                                   input logic [7:0] y);
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] p;
        logic [7:0] q;
        b1 = mem[at];
        b2 = mem[at + 16'd1];
        case (mode)
            4'd0: return {8'h00, b1};
            4'd1: begin
                p = b1 + x;
                return {8'h00, p};
            end
            4'd2: begin
                p = b1 + y;
                return {8'h00, p};
            end
            4'd3: return {b2, b1};
            4'd4: return {b2, b1} + {8'h00, x};
            4'd5: return {b2, b1} + {8'h00, y};
            4'd6: begin
                // Pointer stays in page zero
                p = b1 + x;
                q = p + 8'd1;
                return {mem[{8'h00, q}], mem[{8'h00, p}]};
            end
            default: begin
                q = b1 + 8'd1;
                return {mem[{8'h00, q}], mem[{8'h00, b1}]} + {8'h00, y};
            end
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "first error reached");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_req(input string name, input addr_pkg::mem_req_t got,
                             input addr_pkg::mem_req_t exp);
        if (got !== exp) begin
            fail_run($sformatf(
                "mismatch %s: got addr=%h wdata=%h we=%h expected addr=%h wdata=%h we=%h",
                name, got.addr, got.wdata, got.we, exp.addr, exp.wdata, exp.we));
        end
    endtask

    task automatic write_reg(input addr_pkg::reg_sel_t sel, input logic [7:0] data);
        cfg_we   = 1'b1;
        cfg_sel  = sel;
        cfg_data = data;
        @(negedge clk);
    endtask

    task automatic run_legal(input logic [15:0] entry, input logic [15:0] at,
                             input logic [7:0] ra, input logic [7:0] rx,
                             input logic [7:0] ry);
        int                 n;
        addr_pkg::mem_req_t exp_req;
        n = state_count(entry[7:4]);
        exp_req.addr = effective_addr(entry[7:4], at, rx, ry);
        exp_req.we   = (entry[3:0] != 4'd0);
        case (entry[3:0])
            4'd1: exp_req.wdata = ra;
            4'd2: exp_req.wdata = rx;
            4'd3: exp_req.wdata = ry;
            default: exp_req.wdata = 8'h00;
        endcase
        cfg_we     = 1'b0;
        opcode.raw = entry[15:8];
        pc         = at;
        start      = 1'b1;
        for (int k = 1; k <= n + 1; k++) begin
            @(negedge clk);
            start = 1'b0;
            // Junk host writes while busy, the unit must ignore them
            cfg_we   = (k <= n);
            cfg_sel  = addr_pkg::reg_sel_t'(2'(take_bits(2) % 16'd3));
            cfg_data = 8'(take_bits(8));
            check_bit("busy", busy, k <= n);
            check_bit("req_valid", req_valid, k == n + 1);
            check_bit("bad_op", bad_op, 1'b0);
        end
        check_req("req", req, exp_req);
        check_word("addr", addr, exp_req.addr);
    endtask

    task automatic run_bad(input logic [7:0] op, input logic [15:0] at);
        cfg_we     = 1'b0;
        opcode.raw = op;
        pc         = at;
        start      = 1'b1;
        for (int k = 1; k <= 3; k++) begin
            @(negedge clk);
            start = 1'b0;
            check_bit("bad_op", bad_op, k == 2);
            check_bit("busy", busy, 1'b0);
            check_bit("req_valid", req_valid, 1'b0);
        end
    endtask

    initial begin : stimulus
        logic [7:0]  ra;
        logic [7:0]  rx;
        logic [7:0]  ry;
        logic [15:0] at;
        int          idx;
        rst_n      = 1'b0;
        cfg_we     = 1'b0;
        cfg_sel    = addr_pkg::sel_a;
        cfg_data   = 8'h00;
        start      = 1'b0;
        opcode.raw = 8'h00;
        pc         = 16'h0000;
        lfsr       = 16'd84;
        for (int i = 0; i < 65536; i++) begin
            mem[16'(i)] = 8'(take_bits(8));
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("busy", busy, 1'b0);
        check_bit("req_valid", req_valid, 1'b0);
        check_bit("bad_op", bad_op, 1'b0);
        @(negedge clk);
        for (int i = 0; i < NUM_OPS; i++) begin
            ra = 8'(take_bits(8));
            rx = 8'(take_bits(8));
            ry = 8'(take_bits(8));
            write_reg(addr_pkg::sel_a, ra);
            // Strobes of the previous instruction last a single cycle
            check_bit("req_valid", req_valid, 1'b0);
            check_bit("bad_op", bad_op, 1'b0);
            write_reg(addr_pkg::sel_x, rx);
            write_reg(addr_pkg::sel_y, ry);
            at = take_bits(16);
            // Sometimes an operand of FF to hit the page-zero wrap
            if (take_bits(3) == 16'd0) begin
                mem[at] = 8'hFF;
            end
            if (take_bits(2) == 16'd0) begin
                idx = int'(take_bits(4));
                run_bad(illegal_ops[idx], at);
            end else begin
                idx = int'(take_bits(5)) % 28;
                run_legal(legal_ops[idx], at, ra, rx, ry);
            end
        end
        $display("Regression passed");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        fail_run("watchdog expired before all instructions finished");
    end

endmodule

//--- sources.f
design/addr_pkg.sv
design/index_reg_bank.sv
design/opcode_decode.sv
design/addr_seq.sv
design/addr_mode_flags.sv
design/addr_datapath.sv
design/addr_unit.sv
verif/addr_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := addr_unit_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
